// File: hw/alu_pkg.sv
package alu_pkg;

	// datapath widths
	localparam int DATA_W     = 32;                 // operand / result width
	localparam int SH_SEL_W   = $clog2(DATA_W);     // shift amount bits from b
	localparam int ZSX_W      = DATA_W + 1;         // zero / sign extended operand
	localparam int DBL_W      = 2 * ZSX_W;          // full multiplier product

	// pipeline depths
	localparam int MUL_STAGES = 4;                  // multiplier register depth
	localparam int REGS_IN    = 1;                  // unit input register
	localparam int REGS_OUT   = 1;                  // unit output register
	localparam int UNIT_LAT   = REGS_IN + MUL_STAGES + REGS_OUT;  // 6 for both units

	// top level opcodes
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,  // a + b
		OP_SUB = 3'd1,  // a - b
		OP_AND = 3'd2,  // a & b
		OP_OR  = 3'd3,  // a | b
		OP_XOR = 3'd4,  // a ^ b
		OP_MUL = 3'd5,  // a * b, ext picks high word
		OP_SHL = 3'd6,  // pow2 / shift, sign of b picks direction
		OP_CPY = 3'd7   // copy b, ext gives the extension word
	} alu_op_e;

	// one request per clock, no handshake
	typedef struct packed {
		alu_op_e           op;
		logic              sgn;  // 1=signed
		logic              ext;  // 1=extended / high word
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
	} alu_req_t;

	// multiply & shift unit controls
	typedef struct packed {
		logic cpy;  // 1=copy b
		logic shl;  // 1=shift
		logic ext;  // 1=high word
		logic sgn;  // 1=signed
	} ms_ctrl_t;

	// add & logic unit operations
	typedef enum logic [2:0] {
		AL_ADD = 3'd0,
		AL_SUB = 3'd1,
		AL_AND = 3'd2,
		AL_OR  = 3'd3,
		AL_XOR = 3'd4
	} al_op_e;

endpackage

// File: hw/vector_sr.sv
`timescale 1ns/1ps

module vector_sr #(
	parameter int REGS  = 1,  // register depth, 0=wire
	parameter int WIDTH = 1   // data width
) (
	input  logic             clk_i,    // clock
	input  logic             rst_n_i,  // sync reset, active low
	input  logic [WIDTH-1:0] data_i,   // data in
	output logic [WIDTH-1:0] data_o    // data out, REGS clocks later
);

	generate
		if (REGS == 0) begin : g_wire
			assign data_o = data_i;  // no delay
		end else begin : g_regs
			logic [REGS-1:0][WIDTH-1:0] sr_r;  // stage 0 is the input end

			always_ff @(posedge clk_i) begin
				if (!rst_n_i) begin
					sr_r <= '0;  // all stages to zero
				end else begin
					sr_r[0] <= data_i;  // load
					for (int i = 1; i < REGS; i++) begin
						sr_r[i] <= sr_r[i-1];  // shift along
					end
				end
			end

			assign data_o = sr_r[REGS-1];  // last stage
		end
	endgenerate

endmodule

// File: hw/alu_multiply.sv
`timescale 1ns/1ps

module alu_multiply (
	input  logic                      clk_i,      // clock
	input  logic                      rst_n_i,    // sync reset, active low
	input  logic [alu_pkg::ZSX_W-1:0] a_i,        // signed operand
	input  logic [alu_pkg::ZSX_W-1:0] b_i,        // signed operand
	output logic [alu_pkg::DBL_W-1:0] product_o   // signed product, 4 clocks later
);

	import alu_pkg::*;

	localparam int LO_W = (ZSX_W + 1) / 2;  // low half, unsigned
	localparam int HI_W = ZSX_W - LO_W;     // high half, signed

	logic signed [ZSX_W-1:0] a_r, b_r;                     // stage 1
	logic signed [LO_W:0]    a_lo, b_lo;                   // low halves, 0 prefixed
	logic signed [HI_W-1:0]  a_hi, b_hi;                   // high halves
	logic signed [DBL_W-1:0] pp_ll_r, pp_lh_r;             // stage 2
	logic signed [DBL_W-1:0] pp_hl_r, pp_hh_r;
	logic signed [DBL_W-1:0] sum_lo_r, sum_hi_r;           // stage 3
	logic signed [DBL_W-1:0] prod_r;                       // stage 4

	// stage 1: operand regs
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			a_r <= '0;
			b_r <= '0;
		end else begin
			a_r <= a_i;
			b_r <= b_i;
		end
	end

	assign a_lo = {1'b0, a_r[LO_W-1:0]};  // keep low half positive
	assign b_lo = {1'b0, b_r[LO_W-1:0]};
	assign a_hi = a_r[ZSX_W-1:LO_W];      // carries the sign
	assign b_hi = b_r[ZSX_W-1:LO_W];

	// stage 2: partial products of the halves
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pp_ll_r <= '0;
			pp_lh_r <= '0;
			pp_hl_r <= '0;
			pp_hh_r <= '0;
		end else begin
			pp_ll_r <= a_lo * b_lo;  // lo x lo
			pp_lh_r <= a_lo * b_hi;  // lo x hi
			pp_hl_r <= a_hi * b_lo;  // hi x lo
			pp_hh_r <= a_hi * b_hi;  // hi x hi
		end
	end

	// stage 3: two partial sums, weighted by position
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			sum_lo_r <= '0;
			sum_hi_r <= '0;
		end else begin
			sum_lo_r <= pp_ll_r + (pp_lh_r <<< LO_W);
			sum_hi_r <= (pp_hh_r <<< (2 * LO_W)) + (pp_hl_r <<< LO_W);
		end
	end

	// stage 4: final sum, exact in DBL_W bits
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			prod_r <= '0;
		end else begin
			prod_r <= sum_lo_r + sum_hi_r;
		end
	end

	assign product_o = prod_r;

endmodule

// File: hw/alu_mult_shift.sv
`timescale 1ns/1ps

module alu_mult_shift (
	input  logic                       clk_i,     // clock
	input  logic                       rst_n_i,   // sync reset, active low
	input  alu_pkg::ms_ctrl_t          ctrl_i,    // cpy / shl / ext / sgn
	input  logic [alu_pkg::DATA_W-1:0] a_i,       // operand
	input  logic [alu_pkg::DATA_W-1:0] b_i,       // operand
	output logic [alu_pkg::DATA_W-1:0] result_o   // result, UNIT_LAT clocks later
);

	import alu_pkg::*;

	typedef struct packed {
		ms_ctrl_t          ctrl;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
	} ms_in_t;

	ms_in_t            in_d, in_q;       // around input regs
	logic [ZSX_W-1:0]  a_sx, b_sx;       // extended per sgn
	logic [ZSX_W-1:0]  a_mux, b_mux;     // multiplier operands
	logic [ZSX_W-1:0]  b_pow2;           // 2^b[SH_SEL_W-1:0]
	logic              b_neg;            // b sign, shift direction
	logic              ext_mux, ext_q;   // word select, before / after delay
	logic [DBL_W-1:0]  product;
	logic [DATA_W-1:0] result;

	assign in_d = '{ctrl: ctrl_i, a: a_i, b: b_i};

	vector_sr #(
		.REGS  (REGS_IN),
		.WIDTH ($bits(ms_in_t))
	) in_regs (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.data_i  (in_d),
		.data_o  (in_q)
	);

	assign b_neg  = in_q.b[DATA_W-1];
	assign a_sx   = {in_q.ctrl.sgn & in_q.a[DATA_W-1], in_q.a};  // zero or sign extend
	assign b_sx   = {in_q.ctrl.sgn & b_neg, in_q.b};
	assign b_pow2 = ZSX_W'(1) << in_q.b[SH_SEL_W-1:0];           // one-hot

	// operand steering, copy > shift > multiply
	always_comb begin
		a_mux   = a_sx;             // multiply by default
		b_mux   = b_sx;
		ext_mux = in_q.ctrl.ext;    // follow request
		if (in_q.ctrl.cpy) begin
			a_mux = ZSX_W'(1);      // 1 * b
		end else if (in_q.ctrl.shl) begin
			b_mux   = b_pow2;
			ext_mux = b_neg;        // right shift lands in the high word
			if (!in_q.ctrl.sgn && !b_neg) begin
				a_mux = ZSX_W'(1);  // unsigned positive gives plain pow2
			end
		end
	end

	alu_multiply u_mul (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.a_i       (a_mux),
		.b_i       (b_mux),
		.product_o (product)
	);

	// word select rides alongside the multiplier
	vector_sr #(
		.REGS  (MUL_STAGES),
		.WIDTH (1)
	) ext_regs (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.data_i  (ext_mux),
		.data_o  (ext_q)
	);

	assign result = ext_q ? product[2*DATA_W-1:DATA_W] : product[DATA_W-1:0];  // high : low

	vector_sr #(
		.REGS  (REGS_OUT),
		.WIDTH (DATA_W)
	) out_regs (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.data_i  (result),
		.data_o  (result_o)
	);

endmodule

// File: hw/alu_add_logic.sv
`timescale 1ns/1ps

module alu_add_logic (
	input  logic                       clk_i,     // clock
	input  logic                       rst_n_i,   // sync reset, active low
	input  alu_pkg::al_op_e            op_i,      // add / sub / and / or / xor
	input  logic [alu_pkg::DATA_W-1:0] a_i,       // operand
	input  logic [alu_pkg::DATA_W-1:0] b_i,       // operand
	output logic [alu_pkg::DATA_W-1:0] result_o   // result, UNIT_LAT clocks later
);

	import alu_pkg::*;

	typedef struct packed {
		al_op_e            op;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
	} al_in_t;

	al_in_t            in_d, in_q;  // around input regs
	logic [DATA_W-1:0] al_res;      // stage 2 result

	assign in_d = '{op: op_i, a: a_i, b: b_i};

	vector_sr #(
		.REGS  (REGS_IN),
		.WIDTH ($bits(al_in_t))
	) in_regs (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.data_i  (in_d),
		.data_o  (in_q)
	);

	// one level of logic, wraps mod 2^DATA_W
	always_comb begin
		case (in_q.op)
			AL_ADD:  al_res = in_q.a + in_q.b;
			AL_SUB:  al_res = in_q.a - in_q.b;
			AL_AND:  al_res = in_q.a & in_q.b;
			AL_OR:   al_res = in_q.a | in_q.b;
			AL_XOR:  al_res = in_q.a ^ in_q.b;
			default: al_res = '0;  // unused encodings
		endcase
	end

	// pad to the multiplier path, last stage is the output reg
	vector_sr #(
		.REGS  (UNIT_LAT - REGS_IN),
		.WIDTH (DATA_W)
	) dly_regs (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.data_i  (al_res),
		.data_o  (result_o)
	);

endmodule

// File: hw/alu_top.sv
`timescale 1ns/1ps

module alu_top (
	input  logic                       clk_i,     // clock
	input  logic                       rst_n_i,   // sync reset, active low
	input  alu_pkg::alu_req_t          req_i,     // one operation per clock
	output logic [alu_pkg::DATA_W-1:0] result_o   // result, UNIT_LAT clocks later
);

	import alu_pkg::*;

	ms_ctrl_t          ms_ctrl;          // multiply & shift controls
	al_op_e            al_op;            // add & logic op
	logic              ms_sel, ms_sel_q; // 1=multiply & shift unit owns the result
	logic [DATA_W-1:0] ms_res, al_res;   // unit outputs

	// opcode decode, unused unit still sees the operands
	always_comb begin
		ms_ctrl = '{cpy: 1'b0, shl: 1'b0, ext: req_i.ext, sgn: req_i.sgn};
		al_op   = AL_ADD;
		ms_sel  = 1'b0;
		case (req_i.op)
			OP_ADD: al_op = AL_ADD;
			OP_SUB: al_op = AL_SUB;
			OP_AND: al_op = AL_AND;
			OP_OR:  al_op = AL_OR;
			OP_XOR: al_op = AL_XOR;
			OP_MUL: ms_sel = 1'b1;  // plain multiply
			OP_SHL: begin
				ms_ctrl.shl = 1'b1;
				ms_sel      = 1'b1;
			end
			OP_CPY: begin
				ms_ctrl.cpy = 1'b1;
				ms_sel      = 1'b1;
			end
			default: ms_sel = 1'b0;
		endcase
	end

	alu_mult_shift u_ms (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.ctrl_i   (ms_ctrl),
		.a_i      (req_i.a),
		.b_i      (req_i.b),
		.result_o (ms_res)
	);

	alu_add_logic u_al (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.op_i     (al_op),
		.a_i      (req_i.a),
		.b_i      (req_i.b),
		.result_o (al_res)
	);

	// unit select follows its operation down the pipe
	vector_sr #(
		.REGS  (UNIT_LAT),
		.WIDTH (1)
	) sel_regs (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.data_i  (ms_sel),
		.data_o  (ms_sel_q)
	);

	assign result_o = ms_sel_q ? ms_res : al_res;  // both units already registered

endmodule

// File: test/tb_alu.sv
`timescale 1ns/1ps

module tb_alu;

	import alu_pkg::*;

	localparam int CLK_PERIOD = 8;   // ns
	localparam int RST_CYCLES = 5;
	localparam int N_CORNER   = 5;   // corner operand values
	localparam int N_RESET    = 6;   // ops issued at reset release
	localparam int N_ADDLOG   = N_CORNER * N_CORNER * 5 + 10 * 5;
	localparam int N_MUL      = N_CORNER * N_CORNER * 4 + 10 * 4;
	localparam int N_SHIFT    = 4 * 32;
	localparam int N_COPY     = 4 * N_CORNER;
	localparam int N_MIX      = 200;
	localparam int N_OPS      = N_RESET + N_ADDLOG + N_MUL + N_SHIFT + N_COPY + N_MIX;
	localparam int WD_CYCLES  = RST_CYCLES + N_OPS + UNIT_LAT + 20;  // run length plus margin

	typedef struct packed {
		logic [31:0]       due;    // cycle count at the sampling edge
		logic [DATA_W-1:0] value;  // model result
	} exp_t;

	logic              clk = 1'b0;
	logic              rst_n;
	alu_req_t          req;
	logic [DATA_W-1:0] result;

	int          cyc;        // rising edges so far
	int          checks;
	int          errors;
	logic [31:0] lfsr;       // random state
	exp_t        exp_q[$];   // results in flight
	string       name_q[$];  // test name per result
	exp_t        done_e;
	string       done_name;

	alu_top uut (
		.clk_i    (clk),
		.rst_n_i  (rst_n),
		.req_i    (req),
		.result_o (result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);  // one step per bit
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] corner(input int i);
		case (i)
			0:       return 32'h0000_0000;
			1:       return 32'h0000_0001;
			2:       return 32'h7fff_ffff;  // most positive
			3:       return 32'h8000_0000;  // most negative
			default: return 32'hffff_ffff;  // all ones
		endcase
	endfunction

	// reference results, 64-bit arithmetic
	function automatic logic [31:0] model(input alu_op_e op, input logic sgn, input logic ext,
			input logic [31:0] a, input logic [31:0] b);
		logic [63:0] wa, wb, prod;
		logic [4:0]  sh;
		sh   = b[4:0];
		wa   = sgn ? {{32{a[31]}}, a} : {32'h0, a};
		wb   = sgn ? {{32{b[31]}}, b} : {32'h0, b};
		prod = '0;
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR:  return a | b;
			OP_XOR: return a ^ b;
			OP_MUL: begin
				prod = wa * wb;
				return ext ? prod[63:32] : prod[31:0];
			end
			OP_SHL: begin
				if (!b[31]) begin
					return sgn ? (a << sh) : (32'h1 << sh);  // left shift or pow2
				end
				prod = wa << sh;  // right by 32 - sh, lands in high word
				return prod[63:32];
			end
			default: return ext ? wb[63:32] : b;  // copy, ext gives the extension
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s expected %08h actual %08h at %0t", name, expected, actual,
				$time);
		end
	endtask

	task automatic expect_result(input string name, input alu_req_t r);
		exp_t e;
		e.due   = cyc + UNIT_LAT;  // sampled at the next rising edge
		e.value = model(r.op, r.sgn, r.ext, r.a, r.b);
		exp_q.push_back(e);
		name_q.push_back($sformatf("%s op %0d", name, r.op));
	endtask

	task automatic issue(input string name, input alu_op_e op, input logic sgn,
			input logic ext, input logic [31:0] a, input logic [31:0] b);
		alu_req_t r;
		r = '{op: op, sgn: sgn, ext: ext, a: a, b: b};
		@(negedge clk);
		req = r;
		expect_result(name, r);
	endtask

	// compare each result on the falling edge it is due
	always @(negedge clk) begin
		if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
			done_e    = exp_q.pop_front();
			done_name = name_q.pop_front();
			check(done_name, done_e.value, result);
		end
	end

	task automatic reset_zeros;
		alu_req_t r;
		r     = '{op: OP_CPY, sgn: 1'b0, ext: 1'b0, a: 32'h1234_5678, b: 32'ha5a5_a5a5};
		rst_n = 1'b0;
		req   = r;  // nonzero, must not leak
		repeat (RST_CYCLES) begin
			@(negedge clk);
			check("reset", '0, result);
		end
		rst_n = 1'b1;
		expect_result("reset", r);  // first op after release
		repeat (N_RESET - 1) begin
			issue("reset", r.op, r.sgn, r.ext, r.a, r.b);
			check("reset", '0, result);  // reset zeros still draining
		end
	endtask

	task automatic add_logic_corners;
		logic [31:0] a, b;
		for (int i = 0; i < N_CORNER; i++) begin
			for (int j = 0; j < N_CORNER; j++) begin
				for (int k = 0; k < 5; k++) begin
					issue("add_logic", alu_op_e'(k), 1'b0, 1'b0, corner(i), corner(j));
				end
			end
		end
		for (int n = 0; n < 10; n++) begin
			rand_bits(32, a);
			rand_bits(32, b);
			for (int k = 0; k < 5; k++) begin
				issue("add_logic", alu_op_e'(k), 1'b0, 1'b0, a, b);
			end
		end
	endtask

	task automatic multiply_words;
		logic [31:0] a, b;
		for (int i = 0; i < N_CORNER; i++) begin
			for (int j = 0; j < N_CORNER; j++) begin
				for (int k = 0; k < 4; k++) begin
					issue("multiply", OP_MUL, 1'(k), 1'(k >> 1), corner(i), corner(j));
				end
			end
		end
		for (int n = 0; n < 10; n++) begin
			rand_bits(32, a);
			rand_bits(32, b);
			for (int k = 0; k < 4; k++) begin
				issue("multiply", OP_MUL, 1'(k), 1'(k >> 1), a, b);
			end
		end
	endtask

	task automatic shift_amounts;
		logic [31:0] a, r, e;
		for (int sh = 0; sh < 32; sh++) begin
			rand_bits(32, a);
			rand_bits(26, r);  // filler between sign and amount
			rand_bits(1, e);   // ext is ignored for shifts
			issue("shift_pow2", OP_SHL, 1'b0, e[0], a, {1'b0, r[25:0], 5'(sh)});
			issue("shift_left", OP_SHL, 1'b1, e[0], a, {1'b0, r[25:0], 5'(sh)});
			issue("shift_right_u", OP_SHL, 1'b0, e[0], a, {1'b1, r[25:0], 5'(sh)});
			issue("shift_right_s", OP_SHL, 1'b1, e[0], {1'(sh), a[30:0]},
				{1'b1, r[25:0], 5'(sh)});  // both signs of a
		end
	endtask

	task automatic copy_extensions;
		logic [31:0] a;
		for (int k = 0; k < 4; k++) begin
			for (int i = 0; i < N_CORNER; i++) begin
				rand_bits(32, a);  // a must not matter
				issue("copy", OP_CPY, 1'(k), 1'(k >> 1), a, corner(i));
			end
		end
	endtask

	task automatic random_mix;
		logic [31:0] op, s, e, a, b;
		for (int n = 0; n < N_MIX; n++) begin
			rand_bits(3, op);
			rand_bits(1, s);
			rand_bits(1, e);
			rand_bits(32, a);
			rand_bits(32, b);
			issue("random_mix", alu_op_e'(op[2:0]), s[0], e[0], a, b);
		end
	endtask

	initial begin
		rst_n  = 1'b0;
		req    = '0;
		lfsr   = 32'h9d62;
		cyc    = 0;
		checks = 0;
		errors = 0;
		reset_zeros();
		add_logic_corners();
		multiply_words();
		shift_amounts();
		copy_extensions();
		random_mix();
		while (exp_q.size() != 0) begin
			@(negedge clk);  // drain the pipe
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles with %0d results still pending",
			WD_CYCLES, exp_q.size());
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sources.f
hw/alu_pkg.sv
hw/vector_sr.sv
hw/alu_multiply.sv
hw/alu_mult_shift.sv
hw/alu_add_logic.sv
hw/alu_top.sv
test/tb_alu.sv

// File: Bender.yml
package:
  name: alu_pipe

sources:
  - files:
      - hw/alu_pkg.sv
      - hw/vector_sr.sv
      - hw/alu_multiply.sv
      - hw/alu_mult_shift.sv
      - hw/alu_add_logic.sv
      - hw/alu_top.sv
  - target: test
    files:
      - test/tb_alu.sv
